//--- rtl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;
	localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;   // addi x0, x0, 0

	// writeback source codes for ctrl_t.wb_sel
	localparam logic [1:0] wb_alu  = 2'd0;
	localparam logic [1:0] wb_load = 2'd1;
	localparam logic [1:0] wb_pc4  = 2'd2;   // link value of jal / jalr

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	// the compare codes leave 0/1 in bit 0 of the result
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt,
		alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      a_pc;            // operand a is pc
		logic      b_imm;           // operand b is the immediate
		logic      branch;
		logic      jump;
		logic      jalr;            // target bit 0 cleared
		logic      mem_read;
		logic      mem_write;
		mem_size_e mem_size;
		logic      load_unsigned;
		logic      reg_write;
		logic [1:0] wb_sel;
	} ctrl_t;

	typedef struct packed {
		word_t     pc;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		ctrl_t     ctrl;
	} idex_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     store_data;
		word_t     pc_plus4;
		reg_addr_t rd;
		ctrl_t     ctrl;
	} exmem_t;

	// a register write, also used as a forwarding source
	typedef struct packed {
		word_t     data;
		reg_addr_t rd;
		logic      write;
	} wb_t;

endpackage

`default_nettype wire

//--- rtl/fetch_stage.sv
`default_nettype none

module fetch_stage
	import rv_core_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  reset_i,
	input  wire logic  stall_i,
	input  wire logic  load_use_stall_i,
	input  wire logic  take_branch_i,
	input  wire word_t branch_target_i,
	input  wire word_t instr_i,
	output word_t      instr_addr_o,
	output word_t      if_instr_o,
	output word_t      if_pc_o
);

	word_t pc_q;   // address of the word now on instr_i
	word_t pc_next;

	// the memory latches pc_next, so a held pc returns the same word again
	always_comb
	begin
		if (!reset_i)
			pc_next = reset_vector;
		else if (stall_i)
			pc_next = pc_q;
		else if (take_branch_i)
			pc_next = branch_target_i;   // flush wins over load-use
		else if (load_use_stall_i)
			pc_next = pc_q;
		else
			pc_next = pc_q + 32'd4;
	end

	assign instr_addr_o = pc_next;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q       <= reset_vector;
			if_instr_o <= nop_instr;
			if_pc_o    <= reset_vector;
		end
		else if (!stall_i)
		begin
			pc_q <= pc_next;
			if (take_branch_i)
				if_instr_o <= nop_instr;   // kill the younger fetch
			else if (!load_use_stall_i)
			begin
				if_instr_o <= instr_i;
				if_pc_o    <= pc_q;
			end
		end
	end

	// targets come from the EX adder, jalr clears only bit 0
	assert property (@(posedge clk_i) disable iff (!reset_i)
		take_branch_i |-> branch_target_i[1:0] == 2'b00)
		else $error("misaligned branch target %h", branch_target_i);

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`default_nettype none

module decode_stage
	import rv_core_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  reset_i,
	input  wire logic  stall_i,
	input  wire logic  flush_i,
	input  wire word_t if_instr_i,
	input  wire word_t if_pc_i,
	input  wire word_t rs1_data_i,
	input  wire word_t rs2_data_i,
	output reg_addr_t  rs1_addr_o,
	output reg_addr_t  rs2_addr_o,
	output logic       load_use_stall_o,
	output idex_t      idex_o
);

	opcode_e opcode;
	logic [2:0] funct3;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t imm;
	ctrl_t ctrl;
	logic uses_rs1, uses_rs2;

	function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic alu_op_e cmp_from_funct3(logic [2:0] f3);
		case (f3)
			3'b001: return alu_ne;
			3'b100: return alu_lt;
			3'b101: return alu_ge;
			3'b110: return alu_ltu;
			3'b111: return alu_geu;
			default: return alu_eq;
		endcase
	endfunction

	assign opcode = opcode_e'(if_instr_i[6:0]);
	assign funct3 = if_instr_i[14:12];

	assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
	assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
	assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
		if_instr_i[30:25], if_instr_i[11:8], 1'b0};
	assign imm_u = {if_instr_i[31:12], 12'b0};
	assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
		if_instr_i[20], if_instr_i[30:21], 1'b0};

	always_comb
	begin
		ctrl = '0;
		ctrl.wb_sel = wb_alu;
		imm = imm_i;
		uses_rs1 = 1'b1;
		uses_rs2 = 1'b0;
		case (opcode)
			opc_lui:
			begin
				ctrl.b_imm = 1'b1;   // x0 + imm
				ctrl.reg_write = 1'b1;
				imm = imm_u;
				uses_rs1 = 1'b0;
			end
			opc_auipc:
			begin
				ctrl.a_pc = 1'b1;
				ctrl.b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_u;
				uses_rs1 = 1'b0;
			end
			opc_jal, opc_jalr:
			begin
				ctrl.jump = 1'b1;
				ctrl.jalr = (opcode == opc_jalr);
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = wb_pc4;
				imm = (opcode == opc_jal) ? imm_j : imm_i;
				uses_rs1 = (opcode == opc_jalr);
			end
			opc_branch:
			begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = cmp_from_funct3(funct3);
				imm = imm_b;
				uses_rs2 = 1'b1;
			end
			opc_load, opc_store:
			begin
				ctrl.b_imm = 1'b1;   // address = rs1 + imm
				ctrl.mem_read = (opcode == opc_load);
				ctrl.mem_write = (opcode == opc_store);
				ctrl.mem_size = mem_size_e'(funct3[1:0]);
				ctrl.load_unsigned = funct3[2];
				ctrl.reg_write = (opcode == opc_load);
				ctrl.wb_sel = wb_load;
				imm = (opcode == opc_store) ? imm_s : imm_i;
				uses_rs2 = (opcode == opc_store);
			end
			opc_op_imm:
			begin
				ctrl.b_imm = 1'b1;
				ctrl.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && if_instr_i[30]);
				ctrl.reg_write = 1'b1;
			end
			opc_op:
			begin
				ctrl.alu_op = alu_from_funct3(funct3, if_instr_i[30]);
				ctrl.reg_write = 1'b1;
				uses_rs2 = 1'b1;
			end
			default:
				uses_rs1 = 1'b0;   // unknown opcode runs as a bubble
		endcase
	end

	// unused sources read x0, so they never forward or stall
	assign rs1_addr_o = uses_rs1 ? if_instr_i[19:15] : 5'd0;
	assign rs2_addr_o = uses_rs2 ? if_instr_i[24:20] : 5'd0;

	assign load_use_stall_o = idex_o.ctrl.mem_read && idex_o.rd != 5'd0 &&
		(idex_o.rd == rs1_addr_o || idex_o.rd == rs2_addr_o);

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			idex_o <= '0;
		else if (!stall_i)
		begin
			if (flush_i || load_use_stall_o)
			begin
				idex_o.ctrl <= '0;   // bubble
				idex_o.rd   <= 5'd0;
			end
			else
			begin
				idex_o.pc       <= if_pc_i;
				idex_o.rs1_data <= rs1_data_i;
				idex_o.rs2_data <= rs2_data_i;
				idex_o.imm      <= imm;
				idex_o.rs1      <= rs1_addr_o;
				idex_o.rs2      <= rs2_addr_o;
				idex_o.rd       <= ctrl.reg_write ? if_instr_i[11:7] : 5'd0;
				idex_o.ctrl     <= ctrl;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none

module register_file
	import rv_core_pkg::*;
(
	input  wire logic      clk_i,
	input  wire logic      reset_i,
	input  wire reg_addr_t rs1_addr_i,
	input  wire reg_addr_t rs2_addr_i,
	input  wire wb_t       wb_i,
	output word_t          rs1_data_o,
	output word_t          rs2_data_o
);

	word_t regs [1:31];   // no storage for x0

	// falling edge write, so ID sees the WB value in the same cycle
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_i.write)
			regs[wb_i.rd] <= wb_i.data;
	end

	assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

	// writes to x0 are dropped before WB
	assert property (@(negedge clk_i) disable iff (!reset_i)
		wb_i.write |-> wb_i.rd != 5'd0)
		else $error("register write to x0");

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`default_nettype none

module execute_stage
	import rv_core_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  reset_i,
	input  wire logic  stall_i,
	input  wire idex_t idex_i,
	input  wire wb_t   mem_fwd_i,
	input  wire wb_t   wb_fwd_i,
	output logic       take_branch_o,
	output word_t      branch_target_o,
	output word_t      mem_addr_o,
	output word_t      store_data_o,
	output exmem_t     exmem_o
);

	fwd_sel_e fwd_a, fwd_b;
	word_t rs1_val, rs2_val;
	word_t op_a, op_b;
	word_t alu_out;
	word_t target_sum;

	// MEM holds the younger result, so it wins over WB
	function automatic fwd_sel_e fwd_source(reg_addr_t rs, wb_t mem_fwd, wb_t wb_fwd);
		if (rs == 5'd0)
			return fwd_none;
		else if (mem_fwd.write && mem_fwd.rd == rs)
			return fwd_mem;
		else if (wb_fwd.write && wb_fwd.rd == rs)
			return fwd_wb;
		else
			return fwd_none;
	endfunction

	assign fwd_a = fwd_source(idex_i.rs1, mem_fwd_i, wb_fwd_i);
	assign fwd_b = fwd_source(idex_i.rs2, mem_fwd_i, wb_fwd_i);

	always_comb
	begin
		case (fwd_a)
			fwd_mem: rs1_val = mem_fwd_i.data;
			fwd_wb:  rs1_val = wb_fwd_i.data;
			default: rs1_val = idex_i.rs1_data;
		endcase
		case (fwd_b)
			fwd_mem: rs2_val = mem_fwd_i.data;
			fwd_wb:  rs2_val = wb_fwd_i.data;
			default: rs2_val = idex_i.rs2_data;
		endcase
	end

	assign op_a = idex_i.ctrl.a_pc ? idex_i.pc : rs1_val;
	assign op_b = idex_i.ctrl.b_imm ? idex_i.imm : rs2_val;

	always_comb
	begin
		case (idex_i.ctrl.alu_op)
			alu_add:  alu_out = op_a + op_b;
			alu_sub:  alu_out = op_a - op_b;
			alu_sll:  alu_out = op_a << op_b[4:0];
			alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
			alu_sltu: alu_out = word_t'(op_a < op_b);
			alu_xor:  alu_out = op_a ^ op_b;
			alu_srl:  alu_out = op_a >> op_b[4:0];
			alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
			alu_or:   alu_out = op_a | op_b;
			alu_and:  alu_out = op_a & op_b;
			alu_eq:   alu_out = word_t'(op_a == op_b);
			alu_ne:   alu_out = word_t'(op_a != op_b);
			alu_lt:   alu_out = word_t'($signed(op_a) < $signed(op_b));
			alu_ge:   alu_out = word_t'($signed(op_a) >= $signed(op_b));
			alu_ltu:  alu_out = word_t'(op_a < op_b);
			default:  alu_out = word_t'(op_a >= op_b);   // geu
		endcase
	end

	// branches compare in the ALU, so the target needs its own adder
	assign target_sum = (idex_i.ctrl.jalr ? rs1_val : idex_i.pc) + idex_i.imm;
	assign branch_target_o = {target_sum[31:1], target_sum[0] & ~idex_i.ctrl.jalr};
	assign take_branch_o = idex_i.ctrl.jump | (idex_i.ctrl.branch & alu_out[0]);

	assign mem_addr_o   = alu_out;
	assign store_data_o = rs2_val;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			exmem_o <= '0;
		else if (!stall_i)
		begin
			exmem_o.alu_result <= alu_out;
			exmem_o.store_data <= rs2_val;
			exmem_o.pc_plus4   <= idex_i.pc + 32'd4;
			exmem_o.rd         <= idex_i.rd;
			exmem_o.ctrl       <= idex_i.ctrl;
		end
	end

endmodule

`default_nettype wire

//--- rtl/load_store_unit.sv
`default_nettype none

module load_store_unit
	import rv_core_pkg::*;
(
	input  wire logic   clk_i,
	input  wire logic   reset_i,
	input  wire logic   stall_i,
	input  wire ctrl_t  ex_ctrl_i,   // control of the instruction in EX
	input  wire exmem_t exmem_i,
	input  wire word_t  mem_addr_i,
	input  wire word_t  store_data_i,
	input  wire word_t  data_i,
	output word_t       data_addr_o,
	output word_t       data_o,
	output logic [3:0]  data_wmask_o,
	output logic        data_wen_o,
	output logic        data_req_o,
	output wb_t         mem_fwd_o,
	output wb_t         wb_o
);

	typedef struct packed {
		word_t     result;      // alu result or pc+4
		word_t     load_data;   // read word moved down to lane 0
		reg_addr_t rd;
		logic      write;
		logic      is_load;
		mem_size_e size;
		logic      load_unsigned;
	} memwb_t;

	logic [1:0] ex_offset;
	logic [3:0] size_mask;
	word_t mem_result;
	word_t load_value;
	memwb_t memwb_q;

	assign ex_offset   = mem_addr_i[1:0];
	assign data_addr_o = {mem_addr_i[31:2], 2'b00};
	assign data_o      = store_data_i << {ex_offset, 3'b000};
	assign data_req_o  = ex_ctrl_i.mem_read | ex_ctrl_i.mem_write;
	assign data_wen_o  = ~ex_ctrl_i.mem_write;   // low for a store

	always_comb
	begin
		case (ex_ctrl_i.mem_size)
			size_byte: size_mask = 4'b0001;
			size_half: size_mask = 4'b0011;
			size_word: size_mask = 4'b1111;
			default:   size_mask = 4'b0000;
		endcase
	end

	assign data_wmask_o = ex_ctrl_i.mem_write ? size_mask << ex_offset : 4'b0000;

	// a load has no data yet in MEM and never forwards from here
	assign mem_result = (exmem_i.ctrl.wb_sel == wb_pc4) ? exmem_i.pc_plus4 : exmem_i.alu_result;
	assign mem_fwd_o = '{
		data:  mem_result,
		rd:    exmem_i.rd,
		write: exmem_i.ctrl.reg_write && exmem_i.rd != 5'd0 && exmem_i.ctrl.wb_sel != wb_load
	};

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			memwb_q <= '0;
		else if (!stall_i)
		begin
			memwb_q.result        <= mem_result;
			memwb_q.load_data     <= data_i >> {exmem_i.alu_result[1:0], 3'b000};
			memwb_q.rd            <= exmem_i.rd;
			memwb_q.write         <= exmem_i.ctrl.reg_write && exmem_i.rd != 5'd0;
			memwb_q.is_load       <= exmem_i.ctrl.wb_sel == wb_load;
			memwb_q.size          <= exmem_i.ctrl.mem_size;
			memwb_q.load_unsigned <= exmem_i.ctrl.load_unsigned;
		end
	end

	always_comb
	begin
		case (memwb_q.size)
			size_byte: load_value = memwb_q.load_unsigned ? {24'b0, memwb_q.load_data[7:0]}
				: {{24{memwb_q.load_data[7]}}, memwb_q.load_data[7:0]};
			size_half: load_value = memwb_q.load_unsigned ? {16'b0, memwb_q.load_data[15:0]}
				: {{16{memwb_q.load_data[15]}}, memwb_q.load_data[15:0]};
			default:   load_value = memwb_q.load_data;
		endcase
	end

	assign wb_o = '{
		data:  memwb_q.is_load ? load_value : memwb_q.result,
		rd:    memwb_q.rd,
		write: memwb_q.write
	};

	// a frozen pipeline keeps the same request on the bus
	assert property (@(posedge clk_i) disable iff (!reset_i)
		stall_i |=> $stable({data_req_o, data_wen_o, data_wmask_o, data_addr_o, data_o}))
		else $error("memory request changed during a stall");

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`default_nettype none

module rv_core
	import rv_core_pkg::*;
(
	input  wire logic  reset_i,   // active low
	input  wire logic  clk_i,
	input  wire word_t data_i,
	output logic [3:0] data_wmask_o,
	output logic       data_wen_o,
	output word_t      data_addr_o,
	output word_t      data_o,
	output logic       data_req_o,
	input  wire logic  data_stall_i,   // freezes every stage
	input  wire word_t instr_i,
	output word_t      instr_addr_o
);

	word_t if_instr, if_pc;
	reg_addr_t rs1_addr, rs2_addr;
	word_t rs1_data, rs2_data;
	logic load_use_stall;
	logic take_branch;
	word_t branch_target;
	idex_t idex;
	exmem_t exmem;
	word_t mem_addr, store_data;
	wb_t mem_fwd, wb;

	fetch_stage fetch_stage_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.stall_i(data_stall_i),
		.load_use_stall_i(load_use_stall),
		.take_branch_i(take_branch),
		.branch_target_i(branch_target),
		.instr_i(instr_i),
		.instr_addr_o(instr_addr_o),
		.if_instr_o(if_instr),
		.if_pc_o(if_pc)
	);

	decode_stage decode_stage_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.stall_i(data_stall_i),
		.flush_i(take_branch),
		.if_instr_i(if_instr),
		.if_pc_i(if_pc),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.rs1_addr_o(rs1_addr),
		.rs2_addr_o(rs2_addr),
		.load_use_stall_o(load_use_stall),
		.idex_o(idex)
	);

	register_file register_file_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.wb_i(wb),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data)
	);

	execute_stage execute_stage_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.stall_i(data_stall_i),
		.idex_i(idex),
		.mem_fwd_i(mem_fwd),
		.wb_fwd_i(wb),
		.take_branch_o(take_branch),
		.branch_target_o(branch_target),
		.mem_addr_o(mem_addr),
		.store_data_o(store_data),
		.exmem_o(exmem)
	);

	load_store_unit load_store_unit_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.stall_i(data_stall_i),
		.ex_ctrl_i(idex.ctrl),
		.exmem_i(exmem),
		.mem_addr_i(mem_addr),
		.store_data_i(store_data),
		.data_i(data_i),
		.data_addr_o(data_addr_o),
		.data_o(data_o),
		.data_wmask_o(data_wmask_o),
		.data_wen_o(data_wen_o),
		.data_req_o(data_req_o),
		.mem_fwd_o(mem_fwd),
		.wb_o(wb)
	);

endmodule

`default_nettype wire

//--- tests/rv_mem_model.sv
`default_nettype none

module rv_mem_model
	import rv_core_pkg::*;
#(
	parameter int instr_words = 64,
	parameter int data_words = 64
)
(
	input  wire logic       clk_i,
	input  wire logic       reset_i,
	input  wire word_t      instr_addr_i,
	output word_t           instr_o,
	input  wire word_t      data_addr_i,
	input  wire word_t      data_i,
	input  wire logic [3:0] data_wmask_i,
	input  wire logic       data_wen_i,
	input  wire logic       data_req_i,
	output word_t           data_o,
	output logic            stall_o
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned stall_seed = 32'h19b5_f8d7;
	localparam int instr_bits = $clog2(instr_words);
	localparam int data_bits = $clog2(data_words);

	word_t imem [instr_words];   // filled by the testbench
	word_t dmem [data_words];

	initial
	begin
		instr_o = nop_instr;
		data_o = '0;
		stall_o = 1'b0;
		// every word of the data memory starts out distinct
		for (int i = 0; i < data_words; i++)
			dmem[i] = 32'hc3a5_0000 ^ (32'(i) * 32'h0101_0101);
	end

	// a held pc reads the same word again
	always @(posedge clk_i)
		instr_o <= imem[instr_addr_i[instr_bits+1:2]];

	// requests only take effect on an edge that is not stalled
	always @(posedge clk_i)
	begin
		if (reset_i && !stall_o && data_req_i)
		begin
			if (!data_wen_i)
			begin
				for (int b = 0; b < 4; b++)
					if (data_wmask_i[b])
						dmem[data_addr_i[data_bits+1:2]][8*b +: 8] <= data_i[8*b +: 8];
			end
			else
				data_o <= dmem[data_addr_i[data_bits+1:2]];   // load answer
		end
	end

	// roughly one cycle in four stalled
	initial
	begin
		void'($urandom(stall_seed));
		forever
		begin
			@(posedge clk_i);
			stall_o <= reset_i && ($urandom % 4 == 0);
		end
	end

endmodule

`default_nettype wire

//--- tests/rv_core_tb.sv
`default_nettype none

module rv_core_tb
	import rv_core_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 100;
	localparam int reset_cycles = 2;
	localparam int instr_words = 64;
	localparam int data_words = 64;
	localparam int cycles_per_word = 20;
	localparam int stall_allowance = 20;   // extra cycles per word for random stalls

	typedef struct packed {
		word_t      addr;
		word_t      data;   // written lanes only, the rest zero
		logic [3:0] mask;
	} store_t;

	logic clk;
	logic reset_n;
	word_t instr, instr_addr;
	word_t rdata, wdata, data_addr;
	logic [3:0] wmask;
	logic wen_n, req, stall;

	word_t program_q[$];
	store_t expected_q[$];
	string store_names[$];
	word_t load_addr_q[$];
	string load_names[$];
	int store_index = 0;
	int load_index = 0;
	int value_errors = 0;
	int mask_errors = 0;
	int other_errors = 0;

	rv_core rv_core_inst (
		.reset_i(reset_n),
		.clk_i(clk),
		.data_i(rdata),
		.data_wmask_o(wmask),
		.data_wen_o(wen_n),
		.data_addr_o(data_addr),
		.data_o(wdata),
		.data_req_o(req),
		.data_stall_i(stall),
		.instr_i(instr),
		.instr_addr_o(instr_addr)
	);

	rv_mem_model #(
		.instr_words(instr_words),
		.data_words(data_words)
	) rv_mem_model_inst (
		.clk_i(clk),
		.reset_i(reset_n),
		.instr_addr_i(instr_addr),
		.instr_o(instr),
		.data_addr_i(data_addr),
		.data_i(wdata),
		.data_wmask_i(wmask),
		.data_wen_i(wen_n),
		.data_req_i(req),
		.data_o(rdata),
		.stall_o(stall)
	);

	// RV32I instruction formats
	function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
		reg_addr_t rd, opcode_e op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3, reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd, opcode_e op);
		return {imm, rd, op};
	endfunction

	task automatic emit(word_t word);
		program_q.push_back(word);
	endtask

	task automatic expect_store(string name, word_t addr, word_t data, logic [3:0] mask);
		store_names.push_back(name);
		expected_q.push_back({addr, data, mask});
	endtask

	task automatic expect_load(string name, word_t addr);
		load_names.push_back(name);
		load_addr_q.push_back(addr);
	endtask

	task automatic build_program();
		word_t jal_pc;
		emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_op_imm));     // addi x1, x0, 5
		emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, opc_op_imm));   // addi x2, x0, -3
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));           // add x3, x1, x2
		emit(s_type(12'h040, 5'd3, 5'd0, 3'b010));               // sw x3, 0x40(x0)
		expect_store("add_mem_fwd", 32'h40, 32'h0000_0002, 4'hf);
		emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));           // sub x4, x1, x2
		emit(i_type(12'h00f, 5'd4, 3'b100, 5'd5, opc_op_imm));   // xori x5, x4, 0xf
		emit(i_type(12'd4, 5'd5, 3'b001, 5'd6, opc_op_imm));     // slli x6, x5, 4
		emit(i_type(12'h401, 5'd2, 3'b101, 5'd7, opc_op_imm));   // srai x7, x2, 1
		emit(i_type(12'd28, 5'd2, 3'b101, 5'd8, opc_op_imm));    // srli x8, x2, 28
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));           // slt x9, x2, x1
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd10));          // sltu x10, x2, x1
		emit(r_type(7'h00, 5'd8, 5'd6, 3'b110, 5'd11));          // or x11, x6, x8
		emit(r_type(7'h00, 5'd11, 5'd7, 3'b111, 5'd12));         // and x12, x7, x11
		for (int r = 4; r <= 12; r++)
			emit(s_type(12'(4 * r + 52), 5'(r), 5'd0, 3'b010));  // x4..x12 to 0x44..0x64
		expect_store("sub", 32'h44, 32'h0000_0008, 4'hf);
		expect_store("xori", 32'h48, 32'h0000_0007, 4'hf);
		expect_store("slli", 32'h4c, 32'h0000_0070, 4'hf);
		expect_store("srai", 32'h50, 32'hffff_fffe, 4'hf);
		expect_store("srli", 32'h54, 32'h0000_000f, 4'hf);
		expect_store("slt", 32'h58, 32'h0000_0001, 4'hf);
		expect_store("sltu", 32'h5c, 32'h0000_0000, 4'hf);
		expect_store("or", 32'h60, 32'h0000_007f, 4'hf);
		expect_store("and", 32'h64, 32'h0000_007e, 4'hf);
		emit(u_type(20'h12345, 5'd13, opc_lui));                 // lui x13, 0x12345
		emit(i_type(12'h678, 5'd13, 3'b000, 5'd13, opc_op_imm)); // addi x13, x13, 0x678
		emit(s_type(12'h068, 5'd13, 5'd0, 3'b010));
		expect_store("lui_addi", 32'h68, 32'h1234_5678, 4'hf);

		// operands from MEM, from WB and from a register written three back
		emit(i_type(12'd100, 5'd0, 3'b000, 5'd14, opc_op_imm));
		emit(i_type(12'd1, 5'd14, 3'b000, 5'd15, opc_op_imm));
		emit(i_type(12'd2, 5'd14, 3'b000, 5'd16, opc_op_imm));
		emit(i_type(12'd3, 5'd14, 3'b000, 5'd17, opc_op_imm));
		emit(r_type(7'h00, 5'd16, 5'd15, 3'b000, 5'd18));        // add x18, x15, x16
		emit(r_type(7'h00, 5'd17, 5'd18, 3'b000, 5'd18));        // add x18, x18, x17
		emit(s_type(12'h06c, 5'd18, 5'd0, 3'b010));
		expect_store("fwd_chain", 32'h6c, 32'd306, 4'hf);

		emit(i_type(12'h068, 5'd0, 3'b010, 5'd19, opc_load));    // lw x19, 0x68(x0)
		expect_load("load_use", 32'h68);
		emit(i_type(12'd1, 5'd19, 3'b000, 5'd20, opc_op_imm));   // needs the bubble
		emit(s_type(12'h070, 5'd20, 5'd0, 3'b010));
		expect_store("load_use", 32'h70, 32'h1234_5679, 4'hf);

		// x21 = 0x89abcdef for the sub-word accesses
		emit(u_type(20'h89abd, 5'd21, opc_lui));
		emit(i_type(12'hdef, 5'd21, 3'b000, 5'd21, opc_op_imm));
		emit(s_type(12'h075, 5'd21, 5'd0, 3'b000));              // sb x21, 0x75(x0)
		expect_store("sb_lane1", 32'h74, 32'h0000_ef00, 4'b0010);
		emit(s_type(12'h07a, 5'd21, 5'd0, 3'b001));              // sh x21, 0x7a(x0)
		expect_store("sh_upper", 32'h78, 32'hcdef_0000, 4'b1100);
		emit(i_type(12'h075, 5'd0, 3'b000, 5'd22, opc_load));    // lb
		emit(i_type(12'h075, 5'd0, 3'b100, 5'd23, opc_load));    // lbu
		emit(i_type(12'h07a, 5'd0, 3'b001, 5'd24, opc_load));    // lh
		emit(i_type(12'h07a, 5'd0, 3'b101, 5'd25, opc_load));    // lhu
		expect_load("lb", 32'h74);
		expect_load("lbu", 32'h74);
		expect_load("lh", 32'h78);
		expect_load("lhu", 32'h78);
		for (int r = 22; r <= 25; r++)
			emit(s_type(12'(4 * r + 40), 5'(r), 5'd0, 3'b010));  // x22..x25 to 0x80..0x8c
		expect_store("lb", 32'h80, 32'hffff_ffef, 4'hf);
		expect_store("lbu", 32'h84, 32'h0000_00ef, 4'hf);
		expect_store("lh", 32'h88, 32'hffff_cdef, 4'hf);
		expect_store("lhu", 32'h8c, 32'h0000_cdef, 4'hf);

		emit(i_type(12'd1, 5'd0, 3'b000, 5'd26, opc_op_imm));    // addi x26, x0, 1
		emit(b_type(13'd8, 5'd0, 5'd26, 3'b000));                // beq falls through
		emit(s_type(12'h090, 5'd26, 5'd0, 3'b010));
		expect_store("beq_not_taken", 32'h90, 32'h0000_0001, 4'hf);
		emit(b_type(13'd8, 5'd0, 5'd26, 3'b001));                // bne taken
		emit(s_type(12'h094, 5'd26, 5'd0, 3'b010));              // skipped
		jal_pc = 4 * program_q.size();
		emit(j_type(21'd12, 5'd27));                             // jal x27, +12
		emit(s_type(12'h098, 5'd0, 5'd0, 3'b010));               // skipped
		emit(s_type(12'h09c, 5'd0, 5'd0, 3'b010));               // skipped
		emit(s_type(12'h0a0, 5'd27, 5'd0, 3'b010));
		expect_store("jal_link", 32'ha0, jal_pc + 32'd4, 4'hf);
		emit(j_type(21'd0, 5'd0));                               // park in a self loop
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_mask(string name, logic [3:0] expected, logic [3:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch %s mask: expected %b, actual %b", name, expected, actual);
			mask_errors++;
		end
	endtask

	task automatic observe_store(word_t addr, word_t data, logic [3:0] mask);
		store_t entry;
		word_t lanes;
		if (store_index >= expected_q.size())
		begin
			$display("unexpected store to address %h after the last expected one", addr);
			other_errors++;
		end
		else
		begin
			entry = expected_q[store_index];
			lanes = {{8{entry.mask[3]}}, {8{entry.mask[2]}}, {8{entry.mask[1]}},
				{8{entry.mask[0]}}};
			check_word({store_names[store_index], " address"}, entry.addr, addr);
			check_word({store_names[store_index], " data"}, entry.data, data & lanes);
			check_mask(store_names[store_index], entry.mask, mask);
			store_index++;
		end
	endtask

	task automatic observe_load(word_t addr, logic [3:0] mask);
		if (load_index >= load_addr_q.size())
		begin
			$display("unexpected load request to address %h", addr);
			other_errors++;
		end
		else
		begin
			check_word({load_names[load_index], " load address"}, load_addr_q[load_index], addr);
			check_mask({load_names[load_index], " load"}, 4'b0000, mask);
			load_index++;
		end
	endtask

	task automatic finish_run();
		if (load_index != load_addr_q.size())
		begin
			$display("%0d of %0d load requests never reached the memory",
				load_addr_q.size() - load_index, load_addr_q.size());
			other_errors++;
		end
		$display("errors: %0d value, %0d mask, %0d other", value_errors, mask_errors,
			other_errors);
		if (value_errors + mask_errors + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// a request counts once the memory accepts it
	always @(posedge clk)
	begin
		if (reset_n && !stall && req)
		begin
			if (!wen_n)
				observe_store(data_addr, wdata, wmask);
			else
				observe_load(data_addr, wmask);
		end
	end

	initial
	begin
		reset_n = 1'b0;
		build_program();
		for (int i = 0; i < instr_words; i++)
			rv_mem_model_inst.imem[i] = (i < program_q.size()) ? program_q[i] : nop_instr;
		repeat (reset_cycles) @(posedge clk);
		reset_n <= 1'b1;
		while (store_index < expected_q.size())
			@(posedge clk);
		finish_run();
	end

	initial
	begin
		int limit;
		wait (reset_n === 1'b1);
		limit = program_q.size() * (cycles_per_word + stall_allowance);
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d stores missing", limit,
			expected_q.size() - store_index, expected_q.size());
		other_errors++;
		finish_run();
	end

endmodule

`default_nettype wire

//--- all.f
rtl/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/load_store_unit.sv
rtl/rv_core.sv
tests/rv_mem_model.sv
tests/rv_core_tb.sv
